/* design/riscv_isa_pkg.sv */
/*
 * RV32I base ISA definitions for the fetch frontend.
 * Holds the address and instruction widths and the major opcodes.
 */
package riscv_isa_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    // virtual address width of the fetch path
    localparam int unsigned XLEN_VADDR = 32;
    // full word instructions only
    localparam int unsigned INSTR_W = 32;
    // byte distance to the sequential successor
    localparam int unsigned INSTR_BYTES = INSTR_W / 8;
    // major opcode lives in instr[6:0]
    localparam int unsigned OPCODE_W = 7;

    // ------------------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LOAD     = 7'b000_0011,
        OPC_MISC_MEM = 7'b000_1111,
        OPC_OP_IMM   = 7'b001_0011,
        OPC_AUIPC    = 7'b001_0111,
        OPC_STORE    = 7'b010_0011,
        OPC_OP       = 7'b011_0011,
        OPC_LUI      = 7'b011_0111,
        // conditional branches with B-type immediate
        OPC_BRANCH   = 7'b110_0011,
        // indirect jump whose target is unknown at fetch
        OPC_JALR     = 7'b110_0111,
        // direct jump with J-type immediate
        OPC_JAL      = 7'b110_1111,
        OPC_SYSTEM   = 7'b111_0011
    } opcode_e;

endpackage

/* design/frontend_pkg.sv */
/*
 * Fetch frontend types.
 * Memory request and response, back-end resolve, scan and BHT results
 * and the fetch entry handed to the back-end.
 */
package frontend_pkg;

    // fetch address
    typedef logic [riscv_isa_pkg::XLEN_VADDR-1:0] vaddr_t;

    // control-flow class of a fetched instruction
    typedef enum logic [1:0] {
        NO_CF  = 2'd0,
        BRANCH = 2'd1,
        JUMP   = 2'd2
    } cf_e;

    // ------------------------------------------------------------------------
    // instruction memory port
    // ------------------------------------------------------------------------
    // accepted only with req high and kill low
    typedef struct packed {
        logic   req;
        logic   kill;
        vaddr_t vaddr;
    } imem_req_t;

    // data comes back one cycle after the accepted request
    typedef struct packed {
        logic                               valid;
        logic [riscv_isa_pkg::INSTR_W-1:0]  data;
    } imem_rsp_t;

    // ------------------------------------------------------------------------
    // prediction side
    // ------------------------------------------------------------------------
    // resolved control flow from the back-end
    typedef struct packed {
        logic   valid;
        vaddr_t pc;
        vaddr_t target;
        logic   is_taken;
        logic   is_mispredict;
        cf_e    cf;
    } resolve_t;

    // result of scanning one instruction
    typedef struct packed {
        cf_e    cf;
        vaddr_t imm;
    } scan_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    // ------------------------------------------------------------------------
    // back-end entry
    // ------------------------------------------------------------------------
    typedef struct packed {
        vaddr_t                             addr;
        logic [riscv_isa_pkg::INSTR_W-1:0]  instr;
        cf_e                                cf;
        logic                               predicted_taken;
        vaddr_t                             predict_target;
    } fetch_entry_t;

    localparam fetch_entry_t FE_NONE_ENTRY = '0;

endpackage

/* design/branch_scan.sv */
/*
 * Branch scan.
 * Classifies the registered fetch as conditional branch or direct jump
 * and sign-extends its B-type or J-type offset.
 */
module branch_scan (
    input  logic [riscv_isa_pkg::INSTR_W-1:0]   instr_i,
    input  logic                                valid_i,
    output frontend_pkg::scan_t                 scan_o
);
    import riscv_isa_pkg::*;
    import frontend_pkg::*;

    opcode_e                opcode;
    logic [XLEN_VADDR-1:0]  imm_b;
    logic [XLEN_VADDR-1:0]  imm_j;

    assign opcode = opcode_e'(instr_i[OPCODE_W-1:0]);

    // B-type offset with bit 0 always zero
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // J-type offset
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        scan_o.cf  = NO_CF;
        scan_o.imm = '0;
        if (valid_i) begin
            case (opcode)
                OPC_BRANCH: begin
                    scan_o.cf  = BRANCH;
                    scan_o.imm = imm_b;
                end
                OPC_JAL: begin
                    scan_o.cf  = JUMP;
                    scan_o.imm = imm_j;
                end
                // no BTB here so JALR stays sequential like any other opcode
                default: begin
                    scan_o.cf = NO_CF;
                end
            endcase
        end
    end

endmodule

/* design/bht.sv */
/*
 * Branch history table.
 * Two-bit saturating counters with a valid bit per entry, read with the
 * fetched PC and written by branches resolved in the back-end.
 */
module bht #(
    parameter int unsigned BHT_ENTRIES = 64
) (
    input  logic                    clk_i,
    input  logic                    npc_rst_load_q,
    input  frontend_pkg::vaddr_t    vpc_i,
    input  frontend_pkg::resolve_t  resolve_i,
    output frontend_pkg::bht_pred_t pred_o
);
    import frontend_pkg::*;

    localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

    logic [BHT_ENTRIES-1:0] valid_q;
    logic [1:0]             cnt_q [BHT_ENTRIES];

    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       wr_idx;
    logic                   upd;
    logic [1:0]             cnt_old;
    logic [1:0]             cnt_new;

    // word aligned PCs so bits [1:0] are skipped
    assign rd_idx = vpc_i[IDX_W+1:2];
    assign wr_idx = resolve_i.pc[IDX_W+1:2];

    // ------------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------------
    // counter msb gives taken for 2 and 3
    assign pred_o.valid = valid_q[rd_idx];
    assign pred_o.taken = cnt_q[rd_idx][1];

    // ------------------------------------------------------------------------
    // update
    // ------------------------------------------------------------------------
    // only conditional branches train the table
    assign upd     = resolve_i.valid & (resolve_i.cf == BRANCH);
    assign cnt_old = cnt_q[wr_idx];

    always_comb begin
        if (!valid_q[wr_idx]) begin
            // first sighting starts weakly biased
            cnt_new = resolve_i.is_taken ? 2'd2 : 2'd1;
        end else if (resolve_i.is_taken) begin
            cnt_new = (cnt_old == 2'd3) ? 2'd3 : cnt_old + 2'd1;
        end else begin
            cnt_new = (cnt_old == 2'd0) ? 2'd0 : cnt_old - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            valid_q <= '0;
        end else if (upd) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // counter write for the resolved branch
    always_ff @(posedge clk_i) begin
        if (upd) begin
            cnt_q[wr_idx] <= cnt_new;
        end
    end

endmodule

/* design/pc_gen.sv */
/*
 * Next PC generation.
 * Picks the next fetch address from boot, prediction, sequential and
 * back-end redirect sources, drives the memory request and kill, and
 * completes the fetch entry with its prediction.
 */
module pc_gen (
    input  logic                                clk_i,
    input  logic                                npc_rst_load_q,
    input  frontend_pkg::vaddr_t                boot_addr_i,
    input  frontend_pkg::resolve_t              resolved_branch_i,
    input  logic                                eret_i,
    input  frontend_pkg::vaddr_t                epc_i,
    input  logic                                ex_valid_i,
    input  frontend_pkg::vaddr_t                trap_vector_base_i,
    input  logic                                set_pc_commit_i,
    input  frontend_pkg::vaddr_t                pc_commit_i,
    input  logic                                fetch_valid_i,
    input  frontend_pkg::vaddr_t                fetch_addr_i,
    input  logic [riscv_isa_pkg::INSTR_W-1:0]   fetch_instr_i,
    input  frontend_pkg::scan_t                 scan_i,
    input  frontend_pkg::bht_pred_t             bht_i,
    input  logic                                accept_i,
    output frontend_pkg::imem_req_t             imem_req_o,
    output frontend_pkg::fetch_entry_t          entry_o,
    output logic                                flush_o
);
    import riscv_isa_pkg::*;
    import frontend_pkg::*;

    vaddr_t npc_d;
    vaddr_t npc_q;
    vaddr_t predict_target;
    logic   branch_taken;
    logic   bp_valid;
    logic   is_mispredict;
    logic   req;
    logic   kill;
    logic   if_ready;

    // ------------------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------------------
    // dynamic when the BHT knows the branch, else backward taken
    assign branch_taken   = bht_i.valid ? bht_i.taken : scan_i.imm[XLEN_VADDR-1];
    assign bp_valid       = fetch_valid_i & ((scan_i.cf == JUMP)
                            | ((scan_i.cf == BRANCH) & branch_taken));
    assign predict_target = fetch_addr_i + scan_i.imm;

    assign is_mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;
    assign flush_o       = is_mispredict | eret_i | ex_valid_i | set_pc_commit_i;

    // ------------------------------------------------------------------------
    // memory request
    // ------------------------------------------------------------------------
    // kill drops this request and the response landing now
    assign req      = accept_i & ~npc_rst_load_q;
    assign kill     = bp_valid | flush_o;
    assign if_ready = req & ~kill;

    assign imem_req_o.req   = req;
    assign imem_req_o.kill  = kill;
    assign imem_req_o.vaddr = npc_q;

    // later sources override earlier ones
    always_comb begin : npc_select
        if (npc_rst_load_q) begin
            npc_d = boot_addr_i;
        end else begin
            npc_d = npc_q;
        end
        // taken branch or jump in the fetch register
        if (bp_valid) begin
            npc_d = predict_target;
        end else if (fetch_valid_i && !accept_i) begin
            // entry stuck so refetch its successor later
            npc_d = fetch_addr_i + vaddr_t'(INSTR_BYTES);
        end
        if (if_ready) begin
            npc_d = npc_q + vaddr_t'(INSTR_BYTES);
        end
        if (is_mispredict) begin
            npc_d = resolved_branch_i.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end
        // restart after the committing instruction
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + vaddr_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk_i) begin
        npc_q <= npc_d;
    end

    // completed entry for the output buffer
    always_comb begin
        entry_o                 = FE_NONE_ENTRY;
        entry_o.addr            = fetch_addr_i;
        entry_o.instr           = fetch_instr_i;
        entry_o.cf              = scan_i.cf;
        entry_o.predicted_taken = bp_valid;
        if (bp_valid) begin
            entry_o.predict_target = predict_target;
        end
    end

endmodule

/* design/fetch_buffer.sv */
/*
 * Fetch buffer.
 * Registers the memory response with the address of its request and
 * holds one completed entry toward the back-end.
 */
module fetch_buffer (
    input  logic                                clk_i,
    input  logic                                npc_rst_load_q,
    input  frontend_pkg::imem_rsp_t             imem_rsp_i,
    input  frontend_pkg::imem_req_t             req_i,
    input  logic                                flush_i,
    input  frontend_pkg::fetch_entry_t          entry_i,
    output logic                                fetch_valid_o,
    output frontend_pkg::vaddr_t                fetch_addr_o,
    output logic [riscv_isa_pkg::INSTR_W-1:0]   fetch_instr_o,
    output logic                                accept_o,
    output frontend_pkg::fetch_entry_t          fetch_entry_o,
    output logic                                fetch_entry_valid_o,
    input  logic                                fetch_entry_ready_i
);
    import riscv_isa_pkg::*;
    import frontend_pkg::*;

    // outstanding request
    logic                   pend_q;
    vaddr_t                 pend_addr_q;
    // fetch register
    logic                   fetch_valid_q;
    vaddr_t                 fetch_addr_q;
    logic [INSTR_W-1:0]     fetch_instr_q;
    // output buffer
    logic                   out_valid_q;
    fetch_entry_t           out_entry_q;

    logic                   space;
    logic                   move;
    logic                   load_rsp;

    // buffer empty or drained at this edge
    assign space    = ~out_valid_q | fetch_entry_ready_i;
    assign move     = fetch_valid_q & space & ~flush_i;
    // a response hitting a stuck fetch register is dropped and refetched
    assign load_rsp = imem_rsp_i.valid & pend_q & ~req_i.kill & ~flush_i
                      & (~fetch_valid_q | space);
    assign accept_o = space;

    // ------------------------------------------------------------------------
    // request tracking and fetch register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            pend_q        <= 1'b0;
            fetch_valid_q <= 1'b0;
        end else begin
            pend_q <= req_i.req & ~req_i.kill;
            if (flush_i) begin
                fetch_valid_q <= 1'b0;
            end else if (!fetch_valid_q || space) begin
                fetch_valid_q <= load_rsp;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pend_addr_q <= req_i.vaddr;
        if (load_rsp) begin
            fetch_addr_q  <= pend_addr_q;
            fetch_instr_q <= imem_rsp_i.data;
        end
    end

    // ------------------------------------------------------------------------
    // output buffer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q || flush_i) begin
            out_valid_q <= 1'b0;
        end else if (space) begin
            out_valid_q <= move;
        end
    end

    always_ff @(posedge clk_i) begin
        if (move) begin
            out_entry_q <= entry_i;
        end
    end

    assign fetch_valid_o       = fetch_valid_q;
    assign fetch_addr_o        = fetch_addr_q;
    assign fetch_instr_o       = fetch_instr_q;
    assign fetch_entry_o       = out_entry_q;
    assign fetch_entry_valid_o = out_valid_q;

endmodule

/* design/fetch_frontend.sv */
/*
 * Instruction fetch frontend top level.
 * Branch scan and BHT look at the same registered fetch and pc_gen
 * merges both into the next request.
 */
module fetch_frontend #(
    parameter int unsigned BHT_ENTRIES = 64
) (
    input  logic                        clk_i,
    input  logic                        npc_rst_load_q,
    input  frontend_pkg::vaddr_t        boot_addr_i,
    input  frontend_pkg::resolve_t      resolved_branch_i,
    input  logic                        eret_i,
    input  frontend_pkg::vaddr_t        epc_i,
    input  logic                        ex_valid_i,
    input  frontend_pkg::vaddr_t        trap_vector_base_i,
    input  logic                        set_pc_commit_i,
    input  frontend_pkg::vaddr_t        pc_commit_i,
    output frontend_pkg::imem_req_t     imem_req_o,
    input  frontend_pkg::imem_rsp_t     imem_rsp_i,
    output frontend_pkg::fetch_entry_t  fetch_entry_o,
    output logic                        fetch_entry_valid_o,
    input  logic                        fetch_entry_ready_i
);
    import riscv_isa_pkg::*;
    import frontend_pkg::*;

    // registered fetch
    logic               fetch_valid;
    vaddr_t             fetch_addr;
    logic [INSTR_W-1:0] fetch_instr;
    // pc_gen to fetch_buffer
    logic               accept;
    logic               flush;
    fetch_entry_t       entry;
    scan_t              scan;
    bht_pred_t          bht_pred;

    fetch_buffer i_fetch_buffer (
        .clk_i               ( clk_i               ),
        .npc_rst_load_q      ( npc_rst_load_q      ),
        .imem_rsp_i          ( imem_rsp_i          ),
        .req_i               ( imem_req_o          ),
        .flush_i             ( flush               ),
        .entry_i             ( entry               ),
        .fetch_valid_o       ( fetch_valid         ),
        .fetch_addr_o        ( fetch_addr          ),
        .fetch_instr_o       ( fetch_instr         ),
        .accept_o            ( accept              ),
        .fetch_entry_o       ( fetch_entry_o       ),
        .fetch_entry_valid_o ( fetch_entry_valid_o ),
        .fetch_entry_ready_i ( fetch_entry_ready_i )
    );

    branch_scan i_branch_scan (
        .instr_i ( fetch_instr ),
        .valid_i ( fetch_valid ),
        .scan_o  ( scan        )
    );

    bht #(
        .BHT_ENTRIES ( BHT_ENTRIES )
    ) i_bht (
        .clk_i          ( clk_i             ),
        .npc_rst_load_q ( npc_rst_load_q    ),
        .vpc_i          ( fetch_addr        ),
        .resolve_i      ( resolved_branch_i ),
        .pred_o         ( bht_pred          )
    );

    pc_gen i_pc_gen (
        .clk_i              ( clk_i              ),
        .npc_rst_load_q     ( npc_rst_load_q     ),
        .boot_addr_i        ( boot_addr_i        ),
        .resolved_branch_i  ( resolved_branch_i  ),
        .eret_i             ( eret_i             ),
        .epc_i              ( epc_i              ),
        .ex_valid_i         ( ex_valid_i         ),
        .trap_vector_base_i ( trap_vector_base_i ),
        .set_pc_commit_i    ( set_pc_commit_i    ),
        .pc_commit_i        ( pc_commit_i        ),
        .fetch_valid_i      ( fetch_valid        ),
        .fetch_addr_i       ( fetch_addr         ),
        .fetch_instr_i      ( fetch_instr        ),
        .scan_i             ( scan               ),
        .bht_i              ( bht_pred           ),
        .accept_i           ( accept             ),
        .imem_req_o         ( imem_req_o         ),
        .entry_o            ( entry              ),
        .flush_o            ( flush              )
    );

endmodule

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock and reset.
 * 20 ns clock, reset held for the first 16 rising edges.
 */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // release lands 2 ns after the edge like every other input
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule

/* bench/fetch_frontend_asserts.sv */
/*
 * Concurrent checks on the fetch frontend top level.
 * Output handshake stability, quiet memory port and empty buffer in reset,
 * kill and buffer flush on redirect.
 */
module fetch_frontend_asserts (
    input  logic                        clk_i,
    input  logic                        npc_rst_load_q,
    input  frontend_pkg::imem_req_t     imem_req_i,
    input  frontend_pkg::resolve_t      resolved_branch_i,
    input  logic                        eret_i,
    input  logic                        ex_valid_i,
    input  logic                        set_pc_commit_i,
    input  logic                        flush_i,
    input  frontend_pkg::fetch_entry_t  entry_i,
    input  logic                        entry_valid_i,
    input  logic                        entry_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import frontend_pkg::*;

    logic redirect;

    assign redirect = (resolved_branch_i.valid & resolved_branch_i.is_mispredict)
                      | eret_i | ex_valid_i | set_pc_commit_i;

    // ------------------------------------------------------------------------
    // properties
    // ------------------------------------------------------------------------
    // a flush may legally drop the held entry
    hold_until_ready: assert property (@(posedge clk_i) disable iff (npc_rst_load_q)
        entry_valid_i && !entry_ready_i && !flush_i |=> entry_valid_i && $stable(entry_i))
        else $error("fetch entry dropped or changed before ready");

    // the output buffer is empty once reset has been seen
    no_req_in_reset: assert property (@(posedge clk_i)
        npc_rst_load_q |-> !imem_req_i.req ##1 !entry_valid_i)
        else $error("memory request or fetch entry during reset");

    // the held entry is gone one cycle after the redirect
    redirect_kills: assert property (@(posedge clk_i) disable iff (npc_rst_load_q)
        redirect |-> imem_req_i.kill ##1 !entry_valid_i)
        else $error("redirect without kill or without buffer flush");

endmodule

bind fetch_frontend fetch_frontend_asserts asserts0 (
    .clk_i             ( clk_i               ),
    .npc_rst_load_q    ( npc_rst_load_q      ),
    .imem_req_i        ( imem_req_o          ),
    .resolved_branch_i ( resolved_branch_i   ),
    .eret_i            ( eret_i              ),
    .ex_valid_i        ( ex_valid_i          ),
    .set_pc_commit_i   ( set_pc_commit_i     ),
    .flush_i           ( flush               ),
    .entry_i           ( fetch_entry_o       ),
    .entry_valid_i     ( fetch_entry_valid_o ),
    .entry_ready_i     ( fetch_entry_ready_i )
);

/* bench/tb_fetch_frontend.sv */
/*
 * Fetch frontend testbench.
 * Memory model, redirect events and expected entries come from the
 * stimulus file, back-end ready is pseudo random.
 */
module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 100ps;
    import frontend_pkg::*;

    logic           clk;
    logic           rst;
    vaddr_t         boot_addr;
    resolve_t       resolved_branch;
    logic           eret;
    vaddr_t         epc;
    logic           ex_valid;
    vaddr_t         trap_base;
    logic           set_pc_commit;
    vaddr_t         pc_commit;
    imem_req_t      imem_req;
    imem_rsp_t      imem_rsp;
    fetch_entry_t   entry;
    logic           entry_valid;
    logic           entry_ready;

    // raw stimulus words and the sparse memory image
    logic [31:0]    stim [0:255];
    logic [31:0]    mem [logic [31:0]];
    int             n_mem;
    int             n_evt;
    int             n_exp;
    int             evt_base;
    int             exp_base;
    int             idx;
    int             evt_ptr;
    int             cycles;
    int             limit;
    logic [15:0]    lfsr;
    logic           hs;
    logic           mem_acc;
    logic           fire;
    vaddr_t         mem_addr;
    fetch_entry_t   got;

    tb_clock_gen clk_gen0 (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    fetch_frontend #(
        .BHT_ENTRIES ( 64 )
    ) dut0 (
        .clk_i               ( clk             ),
        .npc_rst_load_q      ( rst             ),
        .boot_addr_i         ( boot_addr       ),
        .resolved_branch_i   ( resolved_branch ),
        .eret_i              ( eret            ),
        .epc_i               ( epc             ),
        .ex_valid_i          ( ex_valid        ),
        .trap_vector_base_i  ( trap_base       ),
        .set_pc_commit_i     ( set_pc_commit   ),
        .pc_commit_i         ( pc_commit       ),
        .imem_req_o          ( imem_req        ),
        .imem_rsp_i          ( imem_rsp        ),
        .fetch_entry_o       ( entry           ),
        .fetch_entry_valid_o ( entry_valid     ),
        .fetch_entry_ready_i ( entry_ready     )
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // galois lfsr stepped once per ready bit
    function automatic logic next_ready_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    // unlisted words are OP-IMM with an address dependent body
    function automatic logic [31:0] mem_word(logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[24:0] ^ a[31:7], 7'h13};
    endfunction

    task automatic check_value(string name, logic [31:0] got_v, logic [31:0] exp_v);
        if (got_v !== exp_v) begin
            $display("Mismatch %s: got %h, expected %h", name, got_v, exp_v);
            $display("Simulation finished: FAIL");
            $fatal(1, "fetch entry check failed");
        end
    endtask

    task automatic verify_entry(int n, fetch_entry_t e);
        int b;
        b = exp_base + 5 * n;
        check_value("fetch_entry_o.addr", e.addr, stim[b]);
        check_value("fetch_entry_o.instr", e.instr, stim[b+1]);
        check_value("fetch_entry_o.cf", {30'b0, e.cf}, stim[b+2]);
        check_value("fetch_entry_o.predicted_taken", {31'b0, e.predicted_taken}, stim[b+3]);
        check_value("fetch_entry_o.predict_target", e.predict_target, stim[b+4]);
    endtask

    task automatic clear_events();
        resolved_branch = '0;
        eret            = 1'b0;
        ex_valid        = 1'b0;
        set_pc_commit   = 1'b0;
    endtask

    // event kind 1 is a mispredict, 2 an eret, 3 a trap and 4 a commit
    task automatic drive_event(int e);
        logic [31:0] kind;
        logic [31:0] pc;
        logic [31:0] tgt;
        kind = stim[evt_base + 4*e + 1];
        pc   = stim[evt_base + 4*e + 2];
        tgt  = stim[evt_base + 4*e + 3];
        case (kind)
            1: begin
                resolved_branch.valid         = 1'b1;
                resolved_branch.pc            = pc;
                resolved_branch.target        = tgt;
                resolved_branch.is_taken      = 1'b1;
                resolved_branch.is_mispredict = 1'b1;
                resolved_branch.cf            = BRANCH;
            end
            2: begin
                eret = 1'b1;
                epc  = tgt;
            end
            3: begin
                ex_valid  = 1'b1;
                trap_base = tgt;
            end
            4: begin
                set_pc_commit = 1'b1;
                pc_commit     = tgt;
            end
            default: begin
                $display("Stimulus file holds an unknown event kind %0d", kind);
                $display("Simulation finished: FAIL");
                $fatal(1, "bad stimulus");
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        boot_addr   = 32'h0000_1000;
        epc         = '0;
        trap_base   = '0;
        pc_commit   = '0;
        imem_rsp    = '0;
        entry_ready = 1'b0;
        clear_events();
        lfsr    = 16'd23601;
        idx     = 0;
        evt_ptr = 0;
        cycles  = 0;

        $readmemh("bench/fetch_stimulus.txt", stim);
        if (stim[0] === 'x) begin
            $display("Stimulus file could not be read");
            $display("Simulation finished: FAIL");
            $fatal(1, "no stimulus");
        end
        n_mem = stim[0];
        for (int i = 0; i < n_mem; i++) begin
            mem[stim[1 + 2*i]] = stim[2 + 2*i];
        end
        evt_base = 2 + 2*n_mem;
        n_evt    = stim[evt_base - 1];
        exp_base = evt_base + 4*n_evt + 1;
        n_exp    = stim[exp_base - 1];
        // reset plus a generous budget per entry
        limit    = 16 + 40 * n_exp;

        while (idx < n_exp) begin
            // everything is stable at the falling edge
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles with %0d of %0d entries received",
                         cycles, idx, n_exp);
                $display("Simulation finished: FAIL");
                $fatal(1, "run timed out");
            end
            hs       = entry_valid && entry_ready;
            got      = entry;
            mem_acc  = imem_req.req && !imem_req.kill;
            mem_addr = imem_req.vaddr;
            fire     = 1'b0;
            if (hs) begin
                verify_entry(idx, got);
                if (evt_ptr < n_evt && stim[evt_base + 4*evt_ptr] == idx) begin
                    fire = 1'b1;
                end
                idx++;
            end

            @(posedge clk);
            #2;
            imem_rsp.valid = mem_acc;
            imem_rsp.data  = mem_acc ? mem_word(mem_addr) : '0;
            clear_events();
            if (fire) begin
                drive_event(evt_ptr);
                evt_ptr++;
                entry_ready = 1'b0;
            end else begin
                entry_ready = next_ready_bit();
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* fetch_frontend.f */
design/riscv_isa_pkg.sv
design/frontend_pkg.sv
design/branch_scan.sv
design/bht.sv
design/pc_gen.sv
design/fetch_buffer.sv
design/fetch_frontend.sv
bench/tb_clock_gen.sv
bench/fetch_frontend_asserts.sv
bench/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - design/riscv_isa_pkg.sv
  - design/frontend_pkg.sv
  - design/branch_scan.sv
  - design/bht.sv
  - design/pc_gen.sv
  - design/fetch_buffer.sv
  - design/fetch_frontend.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/fetch_frontend_asserts.sv
      - bench/tb_fetch_frontend.sv

/* bench/fetch_stimulus.txt */
// memory: word count, then address and data per line
// events: count, then entry index, kind (1 mispredict 2 eret 3 trap 4 commit), pc, target
// expected: count, then addr, instr, cf, predicted_taken, predict_target
0c
00001000 00100093
00001004 00200113
00001008 0200006F
00001028 00300193
0000102C 00000863
00001030 00400213
00001034 FE000CE3
0000103C 00500293
00001040 00600313
00002000 00700393
00003004 00800413
00003008 00900493
04
00000007 00000001 0000102C 0000103C
00000009 00000002 00000000 00002000
0000000A 00000003 00000000 0000102C
0000000D 00000004 00000000 00003000
10
00001000 00100093 00000000 00000000 00000000
00001004 00200113 00000000 00000000 00000000
00001008 0200006F 00000002 00000001 00001028
00001028 00300193 00000000 00000000 00000000
0000102C 00000863 00000001 00000000 00000000
00001030 00400213 00000000 00000000 00000000
00001034 FE000CE3 00000001 00000001 0000102C
0000102C 00000863 00000001 00000000 00000000
0000103C 00500293 00000000 00000000 00000000
00001040 00600313 00000000 00000000 00000000
00002000 00700393 00000000 00000000 00000000
0000102C 00000863 00000001 00000001 0000103C
0000103C 00500293 00000000 00000000 00000000
00001040 00600313 00000000 00000000 00000000
00003004 00800413 00000000 00000000 00000000
00003008 00900493 00000000 00000000 00000000
